// File: src.f
+incdir+verilog
verilog/icache_pkg.sv
verilog/mem_bus_pkg.sv
verilog/ic_fill_if.sv
verilog/ic_bank.sv
verilog/icache_ctrl.sv
verilog/ic_fetch_align.sv
verilog/icache_top.sv
dv/tb_clkgen.sv
dv/icache_asserts.sv
dv/icache_tb.sv

// File: dv/icache_tb.sv
// Instruction cache testbench
`timescale 1ns/10ps
`include "icache_consts.svh"

module icache_tb;

	localparam int WORDS = `IC_LINE_BYTES / 4;
	localparam int OFF_W = $clog2(`IC_LINE_BYTES);
	localparam int N_PIPE = 12;

	logic                    clk;
	logic                    arst_n;
	logic                    fetch_valid;
	icache_pkg::fetch_addr_t fetch_addr;
	logic                    fetch_ready;
	logic                    resp_valid;
	logic                    resp_hit;
	icache_pkg::bundle_t     resp_bundle;
	logic                    inv_all;
	logic                    mem_req;
	mem_bus_pkg::mem_addr_t  mem_addr;
	logic                    mem_ack;
	mem_bus_pkg::mem_line_t  mem_line;

	int     err_cnt = 0;
	int     test_cnt = 0;
	int     fail_tests = 0;
	int     cycle_cnt = 0;
	integer mem_seed = 32'hc9de;
	integer stim_seed = 32'hc9de;

	// Line numbers seen on the memory port in the order they were requested
	mem_bus_pkg::mem_addr_t req_log [$];

	// Bundle of the latest hit, which a miss leaves in place on resp_bundle
	icache_pkg::bundle_t last_bundle;
	bit                  have_hit = 1'b0;

	tb_clkgen u_clkgen (.clk);

	icache_top u_dut (
		.clk, .arst_n, .fetch_valid, .fetch_addr, .fetch_ready,
		.resp_valid, .resp_hit, .resp_bundle, .inv_all,
		.mem_req, .mem_addr, .mem_ack, .mem_line
	);

	always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

	// Inputs change and outputs are read 2 ns after the rising edge
	task automatic tick();
		@(posedge clk);
		#2;
	endtask

	// ==========================================================
	// Memory image and expected values
	// ==========================================================

	// Word k of line L holds L in the upper half and k in the lower half
	function automatic logic [31:0] line_word(mem_bus_pkg::mem_addr_t line, int k);
		return {16'(line), 16'(k)};
	endfunction

	function automatic mem_bus_pkg::mem_line_t line_image(mem_bus_pkg::mem_addr_t line);
		mem_bus_pkg::mem_line_t img;
		for (int k = 0; k < WORDS; k++)
			img[32*k +: 32] = line_word(line, k);
		return img;
	endfunction

	// The bundle is the two words from the fetch address on and may run into the next line
	function automatic icache_pkg::bundle_t expected_bundle(icache_pkg::fetch_addr_t addr);
		mem_bus_pkg::mem_addr_t line;
		int                     k;
		line = addr[`IC_ADDR_W-1:OFF_W];
		k    = addr[OFF_W-1:2];
		if (k == WORDS - 1)
			return {line_word(line + 1'b1, 0), line_word(line, k)};
		return {line_word(line, k + 1), line_word(line, k)};
	endfunction

	function automatic icache_pkg::fetch_addr_t line_base(mem_bus_pkg::mem_addr_t line);
		return {line, {OFF_W{1'b0}}};
	endfunction

	// Memory answers after 0 to 5 cycles and holds ack until the request falls
	initial begin : mem_responder
		int delay;
		int guard;
		mem_ack  = 1'b0;
		mem_line = '0;
		forever begin
			tick();
			if (mem_req && !mem_ack) begin
				req_log.push_back(mem_addr);
				delay = $unsigned($random(mem_seed)) % 6;
				repeat (delay) tick();
				mem_line = line_image(mem_addr);
				mem_ack  = 1'b1;
				guard = 0;
				while (mem_req && guard < 20) begin
					tick();
					guard++;
				end
				if (mem_req) begin
					$display("Timeout: mem_req stayed high after mem_ack was raised");
					err_cnt++;
				end
				mem_ack = 1'b0;
			end
		end
	end

	// ==========================================================
	// Compare tasks
	// ==========================================================

	task automatic check_bundle(string name, icache_pkg::bundle_t got, icache_pkg::bundle_t exp);
		if (got !== exp) begin
			$display("Error: %s = %h, expected %h at %0t", name, got, exp, $time);
			err_cnt++;
		end
	endtask

	task automatic check_bit(string name, logic got, logic exp);
		if (got !== exp) begin
			$display("Error: %s = %h, expected %h at %0t", name, got, exp, $time);
			err_cnt++;
		end
	endtask

	task automatic check_mem_addr(string name, mem_bus_pkg::mem_addr_t got,
	                              mem_bus_pkg::mem_addr_t exp);
		if (got !== exp) begin
			$display("Error: %s = %h, expected %h at %0t", name, got, exp, $time);
			err_cnt++;
		end
	endtask

	task automatic report_test(string name, int errs_before);
		test_cnt++;
		if (err_cnt == errs_before) begin
			$display("%s: ok", name);
		end else begin
			fail_tests++;
			$display("%s: %0d errors", name, err_cnt - errs_before);
		end
	endtask

	// ==========================================================
	// Fetch helpers
	// ==========================================================

	task automatic wait_ready(int limit);
		int n;
		n = 0;
		while (!fetch_ready && n < limit) begin
			tick();
			n++;
		end
		if (!fetch_ready) begin
			$display("Timeout: fetch_ready stayed low for %0d cycles", limit);
			err_cnt++;
		end
	endtask

	// Issues one fetch and waits for its response, which must come two edges after acceptance
	task automatic do_fetch(input icache_pkg::fetch_addr_t addr, output logic hit,
	                        output icache_pkg::bundle_t bundle);
		int acc;
		int n;
		wait_ready(200);
		fetch_valid = 1'b1;
		fetch_addr  = addr;
		acc = cycle_cnt + 1;
		tick();
		fetch_valid = 1'b0;
		n = 0;
		while (!resp_valid && n < 8) begin
			tick();
			n++;
		end
		if (!resp_valid) begin
			$display("Timeout: no response for the fetch of address %h", addr);
			err_cnt++;
		end else if (cycle_cnt != acc + 2) begin
			$display("Response for address %h came %0d cycles after acceptance instead of 2",
			         addr, cycle_cnt - acc);
			err_cnt++;
		end
		hit    = resp_hit;
		bundle = resp_bundle;
	endtask

	task automatic fetch_hit(icache_pkg::fetch_addr_t addr);
		logic                hit;
		icache_pkg::bundle_t bundle;
		req_log.delete();
		do_fetch(addr, hit, bundle);
		check_bit("resp_hit", hit, 1'b1);
		check_bundle("resp_bundle", bundle, expected_bundle(addr));
		last_bundle = expected_bundle(addr);
		have_hit    = 1'b1;
		wait_ready(200);
		if (req_log.size() != 0) begin
			$display("Memory saw a refill request for the hitting address %h", addr);
			err_cnt++;
		end
	endtask

	// A miss followed by the refill of both lines in the given order
	task automatic fetch_miss(icache_pkg::fetch_addr_t addr, mem_bus_pkg::mem_addr_t first,
	                          mem_bus_pkg::mem_addr_t second);
		logic                hit;
		icache_pkg::bundle_t bundle;
		req_log.delete();
		do_fetch(addr, hit, bundle);
		check_bit("resp_hit", hit, 1'b0);
		if (have_hit)
			check_bundle("resp_bundle", bundle, last_bundle);
		wait_ready(200);
		if (req_log.size() != 2) begin
			$display("Address %h caused %0d refill requests instead of 2", addr, req_log.size());
			err_cnt++;
		end else begin
			check_mem_addr("mem_addr", req_log[0], first);
			check_mem_addr("mem_addr", req_log[1], second);
		end
	endtask

	// ==========================================================
	// Tests
	// ==========================================================

	task automatic test_reset_miss();
		int e0;
		e0 = err_cnt;
		check_bit("fetch_ready", fetch_ready, 1'b1);
		check_bit("resp_valid", resp_valid, 1'b0);
		check_bit("mem_req", mem_req, 1'b0);
		fetch_miss(16'h0200, 11'h010, 11'h011);
		check_bit("mem_req", mem_req, 1'b0);
		report_test("reset and first miss", e0);
	endtask

	task automatic test_refill_hit();
		int e0;
		e0 = err_cnt;
		fetch_hit(16'h0200);
		fetch_hit(16'h020c);
		fetch_hit(16'h0218);
		report_test("refill then hit", e0);
	endtask

	// Offset 28 of line 0x03f runs into line 0x040, whose tag differs
	task automatic test_line_span();
		int e0;
		e0 = err_cnt;
		fetch_miss(16'h07fc, 11'h040, 11'h03f);
		fetch_hit(16'h07fc);
		report_test("line-spanning fetch", e0);
	endtask

	task automatic test_pipeline();
		icache_pkg::fetch_addr_t addrs [N_PIPE];
		int                      acc [N_PIPE];
		int                      e0;
		int                      r;
		int                      got;
		int                      guard;
		e0 = err_cnt;
		// Fetch lines 0x010 and 0x03f have both of their bank lines present
		for (int i = 0; i < N_PIPE; i++) begin
			r = $random(stim_seed);
			addrs[i] = line_base(r[0] ? 11'h010 : 11'h03f);
			r = $random(stim_seed);
			addrs[i][OFF_W-1:2] = r[2:0];
		end
		req_log.delete();
		wait_ready(200);
		fork
			begin
				for (int i = 0; i < N_PIPE; i++) begin
					if (!fetch_ready) begin
						$display("fetch_ready fell during back-to-back hits");
						err_cnt++;
					end
					fetch_valid = 1'b1;
					fetch_addr  = addrs[i];
					acc[i] = cycle_cnt + 1;
					tick();
				end
				fetch_valid = 1'b0;
			end
			begin
				got = 0;
				guard = 0;
				while (got < N_PIPE && guard < 4 * N_PIPE) begin
					tick();
					guard++;
					if (resp_valid) begin
						check_bit("resp_hit", resp_hit, 1'b1);
						check_bundle("resp_bundle", resp_bundle, expected_bundle(addrs[got]));
						if (cycle_cnt != acc[got] + 2) begin
							$display("Pipelined response %0d came %0d cycles after acceptance",
							         got, cycle_cnt - acc[got]);
							err_cnt++;
						end
						got++;
					end
				end
				if (got < N_PIPE) begin
					$display("Timeout: only %0d of %0d pipelined responses arrived", got, N_PIPE);
					err_cnt++;
				end
			end
		join
		last_bundle = expected_bundle(addrs[N_PIPE-1]);
		have_hit    = 1'b1;
		wait_ready(200);
		if (req_log.size() != 0) begin
			$display("Memory saw a refill request during pipelined hits");
			err_cnt++;
		end
		report_test("pipelined hits", e0);
	endtask

	// Pairs 0x006, 0x026 and 0x046 share set 3 in both banks
	task automatic test_replace();
		int e0;
		e0 = err_cnt;
		fetch_miss(line_base(11'h006), 11'h006, 11'h007);
		fetch_miss(line_base(11'h026), 11'h026, 11'h027);
		fetch_miss(line_base(11'h046), 11'h046, 11'h047);
		fetch_hit(line_base(11'h026) + 16'd8);
		fetch_hit(line_base(11'h046) + 16'd16);
		fetch_miss(line_base(11'h006), 11'h006, 11'h007);
		report_test("replacement", e0);
	endtask

	task automatic test_invalidate();
		int e0;
		e0 = err_cnt;
		fetch_hit(16'h0204);
		wait_ready(200);
		inv_all = 1'b1;
		tick();
		inv_all = 1'b0;
		fetch_miss(16'h0204, 11'h010, 11'h011);
		fetch_hit(16'h0204);
		report_test("invalidation", e0);
	endtask

	// ==========================================================
	// Main sequence
	// ==========================================================

	initial begin : main
		int total;
		arst_n      = 1'b0;
		fetch_valid = 1'b0;
		fetch_addr  = '0;
		inv_all     = 1'b0;
		repeat (8) @(posedge clk);
		#2;
		arst_n = 1'b1;
		tick();

		test_reset_miss();
		test_refill_hit();
		test_line_span();
		test_pipeline();
		test_replace();
		test_invalidate();

		total = err_cnt + u_dut.u_asserts.fail_count;
		$display("Tests run %0d, tests failed %0d, check errors %0d, assertion failures %0d",
		         test_cnt, fail_tests, err_cnt, u_dut.u_asserts.fail_count);
		if (total == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// File: dv/icache_asserts.sv
// Cache handshake assertions
`timescale 1ns/10ps

module icache_asserts (
	input logic                   clk,
	input logic                   arst_n,
	input logic                   fetch_valid,
	input logic                   fetch_ready,
	input logic                   resp_valid,
	input logic                   mem_req,
	input mem_bus_pkg::mem_addr_t mem_addr,
	input logic                   mem_ack
);

	// Count of failed assertions, read by the testbench at the end of the run
	int fail_count = 0;

	// ==========================================================
	// Memory port, four-phase req/ack
	// ==========================================================

	// The request stays up until memory answers it
	req_hold_a: assert property (@(posedge clk) disable iff (!arst_n)
		mem_req && !mem_ack |=> mem_req)
	else begin
		fail_count++;
		$error("mem_req dropped before mem_ack");
	end

	// Memory must see one address for the whole request
	addr_stable_a: assert property (@(posedge clk) disable iff (!arst_n)
		mem_req && !mem_ack |=> $stable(mem_addr))
	else begin
		fail_count++;
		$error("mem_addr changed while mem_req was high");
	end

	// A new request only starts after the previous ack has fallen
	req_after_ack_a: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(mem_req) |-> !$past(mem_ack))
	else begin
		fail_count++;
		$error("mem_req rose while mem_ack was still high");
	end

	// ==========================================================
	// Fetch stream
	// ==========================================================

	// Response is registered two edges after the accept edge, so it is sampled on the third
	resp_latency_a: assert property (@(posedge clk) disable iff (!arst_n)
		resp_valid |-> $past(fetch_valid && fetch_ready, 3))
	else begin
		fail_count++;
		$error("resp_valid without a fetch accepted two cycles earlier");
	end

	// Every accepted fetch gets its response, responses cannot stall
	fetch_resp_a: assert property (@(posedge clk) disable iff (!arst_n)
		fetch_valid && fetch_ready |-> ##3 resp_valid)
	else begin
		fail_count++;
		$error("accepted fetch got no response two cycles later");
	end

endmodule

bind icache_top icache_asserts u_asserts (
	.clk, .arst_n, .fetch_valid, .fetch_ready, .resp_valid,
	.mem_req, .mem_addr, .mem_ack
);

// File: dv/tb_clkgen.sv
// Testbench clock source
`timescale 1ns/10ps

module tb_clkgen (
	output logic clk
);

	// Half of the 40 ns clock period
	localparam int HALF_NS = 20;

	initial clk = 1'b0;

	always #(HALF_NS) clk = ~clk;

endmodule

// File: verilog/icache_top.sv
// Two-bank instruction cache
`timescale 1ns/10ps

module icache_top (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    fetch_valid,
	input  icache_pkg::fetch_addr_t fetch_addr,
	output logic                    fetch_ready,
	output logic                    resp_valid,
	output logic                    resp_hit,
	output icache_pkg::bundle_t     resp_bundle,
	input  logic                    inv_all,
	output logic                    mem_req,
	output mem_bus_pkg::mem_addr_t  mem_addr,
	input  logic                    mem_ack,
	input  mem_bus_pkg::mem_line_t  mem_line
);

	// Stage-1 results of the two banks
	logic                   even_hit;
	logic                   odd_hit;
	icache_pkg::line_data_t even_line;
	icache_pkg::line_data_t odd_line;
	icache_pkg::line_addr_t even_line_addr;
	icache_pkg::line_addr_t odd_line_addr;
	icache_pkg::way_t       even_victim;
	icache_pkg::way_t       odd_victim;

	// Stage-1 fetch info from the controller to the aligner
	logic                   s1_valid;
	logic                   s1_hit;
	icache_pkg::line_off_t  s1_off;
	logic                   s1_swap;

	ic_fill_if fill_bus ();

	// ==========================================================
	// Controller
	// ==========================================================

	icache_ctrl u_ctrl (
		.clk, .arst_n, .fetch_valid, .fetch_addr, .fetch_ready, .inv_all,
		.even_hit, .odd_hit, .even_line_addr, .odd_line_addr,
		.even_victim, .odd_victim, .mem_req, .mem_addr, .mem_ack, .mem_line,
		.fill(fill_bus.ctrl), .s1_valid, .s1_hit, .s1_off, .s1_swap
	);

	// ==========================================================
	// Banks and aligner
	// ==========================================================

	ic_bank #(.ODD(1'b0)) u_bank_even (
		.clk, .arst_n, .fetch_addr, .fill(fill_bus.bank), .hit(even_hit),
		.line(even_line), .line_addr(even_line_addr), .victim_way(even_victim)
	);

	ic_bank #(.ODD(1'b1)) u_bank_odd (
		.clk, .arst_n, .fetch_addr, .fill(fill_bus.bank), .hit(odd_hit),
		.line(odd_line), .line_addr(odd_line_addr), .victim_way(odd_victim)
	);

	ic_fetch_align u_align (
		.clk, .arst_n, .s1_valid, .s1_hit, .s1_off, .s1_swap,
		.even_line, .odd_line, .resp_valid, .resp_hit, .resp_bundle
	);

endmodule

// File: verilog/ic_fetch_align.sv
// Fetch bundle aligner
`timescale 1ns/10ps

module ic_fetch_align (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   s1_valid,
	input  logic                   s1_hit,
	input  icache_pkg::line_off_t  s1_off,
	input  logic                   s1_swap,
	input  icache_pkg::line_data_t even_line,
	input  icache_pkg::line_data_t odd_line,
	output logic                   resp_valid,
	output logic                   resp_hit,
	output icache_pkg::bundle_t    resp_bundle
);

	// Two consecutive lines, the one holding the fetch address in the low half
	logic [2*$bits(icache_pkg::line_data_t)-1:0] pair;
	icache_pkg::bundle_t                          bundle;

	assign pair = s1_swap ? {even_line, odd_line} : {odd_line, even_line};

	// Byte offset scaled to a bit index, the window may run into the upper line
	assign bundle = pair[{s1_off, 3'b000} +: $bits(icache_pkg::bundle_t)];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			resp_valid <= 1'b0;
			resp_hit   <= 1'b0;
		end else begin
			resp_valid <= s1_valid;
			resp_hit   <= s1_valid && s1_hit;
		end
	end

	// Bundle only moves on a hit and keeps its last value otherwise
	always_ff @(posedge clk) begin
		if (s1_valid && s1_hit)
			resp_bundle <= bundle;
	end

endmodule

// File: verilog/icache_ctrl.sv
// Instruction cache controller
`timescale 1ns/10ps

module icache_ctrl (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    fetch_valid,
	input  icache_pkg::fetch_addr_t fetch_addr,
	output logic                    fetch_ready,
	input  logic                    inv_all,
	input  logic                    even_hit,
	input  logic                    odd_hit,
	input  icache_pkg::line_addr_t  even_line_addr,
	input  icache_pkg::line_addr_t  odd_line_addr,
	input  icache_pkg::way_t        even_victim,
	input  icache_pkg::way_t        odd_victim,
	output logic                    mem_req,
	output mem_bus_pkg::mem_addr_t  mem_addr,
	input  logic                    mem_ack,
	input  mem_bus_pkg::mem_line_t  mem_line,
	ic_fill_if.ctrl                 fill,
	output logic                    s1_valid,
	output logic                    s1_hit,
	output icache_pkg::line_off_t   s1_off,
	output logic                    s1_swap
);

	icache_pkg::ctrl_state_t state_q;

	// Fetch pipeline, stage 0 lines up with the bank read, stage 1 with the compare
	logic                    s0_valid_q;
	logic                    s1_valid_q;
	icache_pkg::fetch_addr_t s0_addr_q;
	icache_pkg::fetch_addr_t s1_addr_q;

	// Refill context captured on a miss
	icache_pkg::line_addr_t  even_addr_q;
	icache_pkg::line_addr_t  odd_addr_q;
	icache_pkg::way_t        even_vic_q;
	icache_pkg::way_t        odd_vic_q;
	logic                    need_odd_q;
	logic                    cur_odd_q;
	logic                    inv_pend_q;

	logic                    idle;
	logic                    miss_start;
	logic                    fill_grant;

	// ==========================================================
	// Fetch pipeline
	// ==========================================================

	assign idle        = (state_q == icache_pkg::ST_IDLE);
	assign fetch_ready = idle;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			s0_valid_q <= 1'b0;
			s1_valid_q <= 1'b0;
		end else begin
			s0_valid_q <= fetch_valid && fetch_ready;
			s1_valid_q <= s0_valid_q;
		end
	end

	always_ff @(posedge clk) begin
		s0_addr_q <= fetch_addr;
		s1_addr_q <= s0_addr_q;
	end

	// A window may span two lines, so both banks must hit
	assign s1_valid = s1_valid_q;
	assign s1_hit   = even_hit && odd_hit;
	assign s1_off   = s1_addr_q[$bits(icache_pkg::line_off_t)-1:0];
	// Odd fetch line means the odd bank holds the first half
	assign s1_swap  = s1_addr_q[$bits(icache_pkg::line_off_t)];

	// Misses seen while a refill runs are reported but not serviced
	assign miss_start = s1_valid_q && !s1_hit && idle;

	// ==========================================================
	// Refill sequencer
	// ==========================================================

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state_q    <= icache_pkg::ST_IDLE;
			need_odd_q <= 1'b0;
			cur_odd_q  <= 1'b0;
		end else begin
			case (state_q)
				icache_pkg::ST_IDLE: begin
					if (miss_start) begin
						// Even line goes first unless it is already present
						need_odd_q <= !odd_hit;
						cur_odd_q  <= even_hit;
						state_q    <= icache_pkg::ST_REQ;
					end
				end
				icache_pkg::ST_REQ: begin
					if (mem_ack)
						state_q <= icache_pkg::ST_RELEASE;
				end
				icache_pkg::ST_RELEASE: begin
					// Next request waits for the ack of the previous one to fall
					if (!mem_ack) begin
						if (!cur_odd_q && need_odd_q) begin
							cur_odd_q <= 1'b1;
							state_q   <= icache_pkg::ST_REQ;
						end else begin
							state_q <= icache_pkg::ST_IDLE;
						end
					end
				end
				default: state_q <= icache_pkg::ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (miss_start) begin
			even_addr_q <= even_line_addr;
			odd_addr_q  <= odd_line_addr;
			even_vic_q  <= even_victim;
			odd_vic_q   <= odd_victim;
		end
	end

	// Invalidation arriving during a refill waits for the idle state
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			inv_pend_q <= 1'b0;
		else if (idle)
			inv_pend_q <= 1'b0;
		else if (inv_all)
			inv_pend_q <= 1'b1;
	end

	// ==========================================================
	// Memory port and fill bus
	// ==========================================================

	assign mem_req  = (state_q == icache_pkg::ST_REQ);
	assign mem_addr = cur_odd_q ? odd_addr_q : even_addr_q;

	// Line is written on the edge where the ack is first seen
	assign fill_grant     = mem_req && mem_ack;
	assign fill.wr_even   = fill_grant && !cur_odd_q;
	assign fill.wr_odd    = fill_grant && cur_odd_q;
	assign fill.fill_way  = cur_odd_q ? odd_vic_q : even_vic_q;
	assign fill.fill_line = mem_addr;
	assign fill.fill_data = mem_line;
	assign fill.inv_all   = (inv_all || inv_pend_q) && idle;

endmodule

// File: verilog/ic_bank.sv
// Instruction cache parity bank
`timescale 1ns/10ps
`include "icache_consts.svh"

module ic_bank #(
	parameter bit ODD = 1'b0
) (
	input  logic                    clk,
	input  logic                    arst_n,
	input  icache_pkg::fetch_addr_t fetch_addr,
	ic_fill_if.bank                 fill,
	output logic                    hit,
	output icache_pkg::line_data_t  line,
	output icache_pkg::line_addr_t  line_addr,
	output icache_pkg::way_t        victim_way
);

	// Storage arrays, indexed by way then set
	icache_pkg::tag_t       tag_mem  [`IC_WAYS][`IC_SETS];
	icache_pkg::line_data_t data_mem [`IC_WAYS][`IC_SETS];
	logic [`IC_WAYS-1:0][`IC_SETS-1:0] vld_q;
	logic [`IC_SETS-1:0]    tog_q;

	icache_pkg::line_addr_t fetch_line;
	icache_pkg::line_addr_t bank_line;
	icache_pkg::set_t       bank_set;

	// Read stage registers, loaded at the accept edge
	icache_pkg::line_addr_t rd_line_q;
	icache_pkg::tag_t       rd_tag_q  [`IC_WAYS];
	icache_pkg::line_data_t rd_data_q [`IC_WAYS];
	logic [`IC_WAYS-1:0]    rd_vld_q;
	logic                   rd_tog_q;

	icache_pkg::tag_t       rd_tag_want;
	logic [`IC_WAYS-1:0]    way_hit;
	icache_pkg::line_data_t hit_line;
	icache_pkg::way_t       victim_c;

	logic                   fill_wr;
	icache_pkg::set_t       fill_set;
	icache_pkg::tag_t       fill_tag;

	// ==========================================================
	// Index
	// ==========================================================

	assign fetch_line = fetch_addr[`IC_ADDR_W-1 -: $bits(icache_pkg::line_addr_t)];

	// An odd fetch line needs the next even line, which may carry into the tag
	assign bank_line = ODD ? (fetch_line | icache_pkg::line_addr_t'(1))
	                       : (fetch_line + icache_pkg::line_addr_t'(fetch_line[0]));
	assign bank_set  = bank_line[$bits(icache_pkg::set_t):1];

	assign fill_wr  = ODD ? fill.wr_odd : fill.wr_even;
	assign fill_set = fill.fill_line[$bits(icache_pkg::set_t):1];
	assign fill_tag = fill.fill_line[$bits(icache_pkg::line_addr_t)-1 -: $bits(icache_pkg::tag_t)];

	// ==========================================================
	// Arrays
	// ==========================================================

	always_ff @(posedge clk) begin
		if (fill_wr) begin
			tag_mem[fill.fill_way][fill_set]  <= fill_tag;
			data_mem[fill.fill_way][fill_set] <= fill.fill_data;
		end
	end

	// Tags and data of every way are read each cycle at the fetch set
	always_ff @(posedge clk) begin
		rd_line_q <= bank_line;
		for (int w = 0; w < `IC_WAYS; w++) begin
			rd_tag_q[w]  <= tag_mem[w][bank_set];
			rd_data_q[w] <= data_mem[w][bank_set];
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			vld_q    <= '0;
			tog_q    <= '0;
			rd_vld_q <= '0;
			rd_tog_q <= 1'b0;
			hit      <= 1'b0;
		end else begin
			if (fill.inv_all)
				vld_q <= '0;
			// A fill marks its way valid and moves the set's toggle away from it
			if (fill_wr) begin
				vld_q[fill.fill_way][fill_set] <= 1'b1;
				tog_q[fill_set]                <= ~tog_q[fill_set];
			end
			for (int w = 0; w < `IC_WAYS; w++)
				rd_vld_q[w] <= vld_q[w][bank_set];
			rd_tog_q <= tog_q[bank_set];
			hit      <= |way_hit;
		end
	end

	// ==========================================================
	// Compare
	// ==========================================================

	assign rd_tag_want = rd_line_q[$bits(icache_pkg::line_addr_t)-1 -: $bits(icache_pkg::tag_t)];

	always_comb begin
		hit_line = rd_data_q[0];
		// Toggle bit is the fallback, the lowest invalid way wins over it
		victim_c = icache_pkg::way_t'(rd_tog_q);
		for (int w = `IC_WAYS-1; w >= 0; w--) begin
			way_hit[w] = rd_vld_q[w] && (rd_tag_q[w] == rd_tag_want);
			if (!rd_vld_q[w])
				victim_c = icache_pkg::way_t'(w);
		end
		for (int w = 0; w < `IC_WAYS; w++)
			if (way_hit[w])
				hit_line = rd_data_q[w];
	end

	// Stage-1 results for the controller and the aligner
	always_ff @(posedge clk) begin
		line       <= hit_line;
		line_addr  <= rd_line_q;
		victim_way <= victim_c;
	end

endmodule

// File: verilog/ic_fill_if.sv
// Cache fill and invalidate bus
`timescale 1ns/10ps

interface ic_fill_if;

	// One strobe per parity bank, high for a single cycle per line
	logic                    wr_even;
	logic                    wr_odd;

	// Target way and line of the write
	icache_pkg::way_t        fill_way;
	icache_pkg::line_addr_t  fill_line;
	icache_pkg::line_data_t  fill_data;

	// Clears every valid bit in both banks at the next edge
	logic                    inv_all;

	modport ctrl (output wr_even, wr_odd, fill_way, fill_line, fill_data, inv_all);

	modport bank (input wr_even, wr_odd, fill_way, fill_line, fill_data, inv_all);

endinterface

// File: verilog/mem_bus_pkg.sv
// Refill memory bus types
`include "icache_consts.svh"

package mem_bus_pkg;

	// The bus moves whole lines, so the address is a line number
	typedef logic [`IC_ADDR_W-$clog2(`IC_LINE_BYTES)-1:0] mem_addr_t;

	// One full line of refill data
	typedef logic [`IC_LINE_BYTES*8-1:0] mem_line_t;

endpackage

// File: verilog/icache_pkg.sv
// Instruction cache types
`include "icache_consts.svh"

package icache_pkg;

	// Byte address as presented by the fetch unit
	typedef logic [`IC_ADDR_W-1:0] fetch_addr_t;

	// Line number, the address with the line offset removed
	typedef logic [`IC_ADDR_W-$clog2(`IC_LINE_BYTES)-1:0] line_addr_t;

	// Bit 0 of the line number picks the bank, so the set index starts at bit 1
	typedef logic [$clog2(`IC_SETS)-1:0] set_t;
	typedef logic [`IC_ADDR_W-$clog2(`IC_LINE_BYTES)-$clog2(`IC_SETS)-2:0] tag_t;
	typedef logic [$clog2(`IC_WAYS)-1:0] way_t;

	typedef logic [`IC_LINE_BYTES*8-1:0] line_data_t;
	typedef logic [`IC_BUNDLE_BYTES*8-1:0] bundle_t;
	typedef logic [$clog2(`IC_LINE_BYTES)-1:0] line_off_t;

	// Refill sequencer states
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_REQ,
		ST_RELEASE
	} ctrl_state_t;

endpackage

// File: verilog/icache_consts.svh
// Instruction cache size constants
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// Width of a fetch byte address
`define IC_ADDR_W 16

// Bytes per cache line, the unit of every refill
`define IC_LINE_BYTES 32

// Sets in each parity bank and ways in each set
`define IC_SETS 16
`define IC_WAYS 2

// Bytes returned to the fetch unit per lookup
`define IC_BUNDLE_BYTES 8

`endif
